// File: flist.f
irda_pkg.sv
irda_reg_if.sv
irda_tx.sv
irda_rx.sv
irda_uart_top.sv
tb_clkgen.sv
tb_irda_uart.sv

// File: irda_golden.txt
# columns: command and hex value, one per line.
# div <divider>, send <byte>, expect_rx <byte>, expect_div <divider>
div 00000020
expect_div 00000020
send a5
expect_rx a5
send 00
expect_rx 00
send ff
expect_rx ff
send 3c
send c3
expect_rx 3c
expect_rx c3
div 00000118
expect_div 00000118
send 5a
expect_rx 5a
send 81
send 7e
expect_rx 81
expect_rx 7e
div 00000013
expect_div 00000013
send 01
expect_rx 01
send 80
expect_rx 80
send 55
send aa
expect_rx 55
expect_rx aa
div 00000010
expect_div 00000010
send 96
expect_rx 96
send 69
expect_rx 69

// File: irda_pkg.sv
package irda_pkg;

	// ----------------------------------------
	// register map
	// ----------------------------------------

	// byte address of the 32-bit clock divider register.
	localparam logic [3:0] reg_addr_div = 4'h0;
	// byte address of the data register, used for both transmit and receive.
	localparam logic [3:0] reg_addr_dat = 4'h4;

	// ----------------------------------------
	// frame layout
	// ----------------------------------------

	// data bits carried in one frame, sent LSB first.
	localparam int frame_data_bits = 8;
	// start bit, data bits and stop bit together.
	localparam int frame_bits = 10;
	// idle bit periods sent after reset or after a divider change.
	localparam int guard_bits = 15;

	// the bus write word is seen as a divider value by the divider register
	// and as a byte in the low lane by the data register.
	typedef union packed {
		logic [31:0] div_value;
		struct packed {
			logic [23:0] unused;
			logic [7:0]  tx_byte;
		} dat;
	} reg_word_t;

endpackage

// File: irda_reg_if.sv
`timescale 1ns/1ps

module irda_reg_if import irda_pkg::*; #(
	parameter logic [31:0] div_reset = 32'd1
) (
	input  logic        clk,
	input  logic        resetn,

	// register bus from the system side.
	input  logic [3:0]  reg_addr,
	input  logic [3:0]  reg_we,
	input  logic        reg_re,
	input  reg_word_t   reg_wdata,
	output logic [31:0] reg_rdata,
	output logic        reg_wait,

	// divider and guard request towards both serial engines.
	output logic [31:0] divider,
	output logic        div_written,

	// transmit side.
	input  logic        tx_busy,
	output logic        tx_start,
	output logic [7:0]  tx_byte,

	// receive side.
	input  logic        rx_valid,
	input  logic [7:0]  rx_byte,
	output logic        rx_read
);

	logic div_sel;
	logic dat_sel;
	logic any_we;

	// ----------------------------------------
	// address decode
	// ----------------------------------------

	assign div_sel = (reg_addr == reg_addr_div);
	assign dat_sel = (reg_addr == reg_addr_dat);
	assign any_we  = |reg_we;

	// any byte enable on the divider counts as a divider write.
	// the transmitter uses this strobe to schedule an idle guard frame.
	assign div_written = div_sel && any_we;

	// a data write is a transmit request. it is held by the master
	// until the transmitter has room, so the strobe may last several cycles.
	assign tx_start = dat_sel && any_we;
	assign tx_byte  = reg_wdata.dat.tx_byte;

	// the wait level only rises while a data write is presented.
	// the byte is taken in the first cycle where tx_start is high and this is low.
	assign reg_wait = tx_start && tx_busy;

	// a data read releases the receive holding buffer at the next edge.
	assign rx_read = dat_sel && reg_re;

	// ----------------------------------------
	// divider register
	// ----------------------------------------

	// each byte enable updates its own lane of the divider.
	// lanes without an enable keep their old value.
	always_ff @(posedge clk) begin
		if (!resetn) begin
			divider <= div_reset;
		end else begin
			for (int i = 0; i < 4; i++) begin
				if (div_written && reg_we[i]) begin
					divider[i*8 +: 8] <= reg_wdata.div_value[i*8 +: 8];
				end
			end
		end
	end

	// ----------------------------------------
	// read data
	// ----------------------------------------

	// the read path is combinational from the registers.
	// an empty receive buffer reads back as all ones.
	always_comb begin
		reg_rdata = 32'h0;
		if (div_sel) begin
			reg_rdata = divider;
		end else if (dat_sel) begin
			reg_rdata = rx_valid ? {24'h0, rx_byte} : 32'hffff_ffff;
		end
	end

endmodule

// File: irda_rx.sv
`timescale 1ns/1ps

module irda_rx import irda_pkg::*; (
	input  logic                       clk,
	input  logic                       resetn,
	input  logic [31:0]                divider,
	input  logic                       ser_rx,
	input  logic                       rx_read,
	output logic                       rx_valid,
	output logic [frame_data_bits-1:0] rx_byte
);

	// frame states: idle, start window, one window per data bit, stop window.
	localparam logic [3:0] st_idle  = 4'd0;
	localparam logic [3:0] st_start = 4'd1;
	localparam logic [3:0] st_stop  = 4'(frame_bits);

	// input synchronizer and glitch filter, newest sample in bit 0.
	logic [2:0]                 deglitch;
	logic                       low_seen;
	logic [3:0]                 state;
	// cycles elapsed in the current sampling window.
	logic [31:0]                divcnt;
	logic                       window_end;
	logic                       data_state;
	// a low pulse was seen somewhere in the current window.
	logic                       bit_is_zero;
	logic [frame_data_bits-1:0] shift;

	// ----------------------------------------
	// pulse detection
	// ----------------------------------------

	// a low level counts only once it has been held for two samples.
	// single cycle dips on the line are ignored.
	assign low_seen = !deglitch[2] && !deglitch[1];

	// windows are divider + 2 cycles long, the same as the transmit period.
	assign window_end = (divcnt > divider);

	// states between the start window and the stop window carry data.
	assign data_state = (state > st_start) && (state < st_stop);

	// ----------------------------------------
	// frame control
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (!resetn) begin
			// the filter starts at the idle high level so reset is not a start pulse.
			deglitch    <= 3'b111;
			state       <= st_idle;
			divcnt      <= 32'd0;
			bit_is_zero <= 1'b0;
			rx_valid    <= 1'b0;
		end else begin
			deglitch <= {deglitch[1:0], ser_rx};

			// a read empties the buffer, a byte stored in the same cycle wins.
			if (rx_read) begin
				rx_valid <= 1'b0;
			end

			// the zero flag is cleared at the start of each window.
			if (divcnt == 32'd0) begin
				bit_is_zero <= 1'b0;
			end else if (low_seen) begin
				bit_is_zero <= 1'b1;
			end

			case (state)
				st_idle: begin
					// the start pulse sits at the front of its bit period.
					// starting half way puts every later window around a data pulse.
					divcnt <= divider >> 1;
					if (low_seen) begin
						state <= st_start;
					end
				end
				default: begin
					if (window_end) begin
						divcnt <= 32'd0;
						if (state == st_stop) begin
							// the byte is complete, it replaces any byte still held.
							rx_valid <= 1'b1;
							state    <= st_idle;
						end else begin
							state <= state + 4'd1;
						end
					end else begin
						divcnt <= divcnt + 32'd1;
					end
				end
			endcase
		end
	end

	// ----------------------------------------
	// data path
	// ----------------------------------------

	// data arrives LSB first, so each bit enters at the top and moves down.
	// the holding buffer takes the byte at the end of the stop window.
	always_ff @(posedge clk) begin
		if (data_state && window_end) begin
			shift <= {!bit_is_zero, shift[frame_data_bits-1:1]};
		end
		if ((state == st_stop) && window_end) begin
			rx_byte <= shift;
		end
	end

endmodule

// File: irda_tx.sv
`timescale 1ns/1ps

module irda_tx import irda_pkg::*; (
	input  logic                       clk,
	input  logic                       resetn,
	input  logic [31:0]                divider,
	input  logic                       div_written,
	input  logic                       tx_start,
	input  logic [frame_data_bits-1:0] tx_byte,
	output logic                       ser_tx,
	output logic                       tx_busy
);

	// bits still to be sent, the current one sits in bit 0.
	logic [frame_bits-1:0] pattern;
	// bit periods left in the current frame or guard frame.
	logic [3:0]            bitcnt;
	// clock cycles elapsed in the current bit period.
	logic [31:0]           divcnt;
	// a divider write arrived while a frame was still running.
	logic                  guard_pend;
	logic                  active;
	logic                  period_end;
	logic                  guard_go;
	logic                  frame_go;

	// ----------------------------------------
	// status and bit timing
	// ----------------------------------------

	assign active = (bitcnt != 4'd0);

	// one bit period spans divider + 2 cycles, divcnt runs 0 to divider + 1.
	assign period_end = active && (divcnt > divider);

	// the transmitter counts as busy while a guard frame is waiting as well.
	// this keeps a new byte from slipping in ahead of the guard.
	assign tx_busy = active || guard_pend;

	// a guard request takes priority over a new byte when the line is free.
	assign guard_go = !active && (guard_pend || div_written);
	assign frame_go = !active && !guard_pend && tx_start;

	// ----------------------------------------
	// pulse shaping
	// ----------------------------------------

	// a zero bit is a positive pulse for the first quarter of the period.
	// a one bit, the idle line and the guard frame keep the line low.
	assign ser_tx = active && !pattern[0] && (divcnt < (divider >> 2));

	// ----------------------------------------
	// frame sequencer
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (!resetn) begin
			// the guard frame is already running in the first cycle out of reset.
			pattern    <= '1;
			bitcnt     <= 4'(guard_bits);
			divcnt     <= 32'd0;
			guard_pend <= 1'b0;
		end else begin
			if (div_written) begin
				guard_pend <= 1'b1;
			end
			if (guard_go) begin
				// an all ones pattern produces no pulses for the whole guard.
				pattern    <= '1;
				bitcnt     <= 4'(guard_bits);
				divcnt     <= 32'd0;
				guard_pend <= 1'b0;
			end else if (frame_go) begin
				// stop bit, data LSB first, then the start bit in bit 0.
				pattern <= {1'b1, tx_byte, 1'b0};
				bitcnt  <= 4'(frame_bits);
				divcnt  <= 32'd0;
			end else if (period_end) begin
				// ones are shifted in behind the data so the tail stays quiet.
				pattern <= {1'b1, pattern[frame_bits-1:1]};
				bitcnt  <= bitcnt - 4'd1;
				divcnt  <= 32'd0;
			end else if (active) begin
				divcnt <= divcnt + 32'd1;
			end
		end
	end

endmodule

// File: irda_uart_top.sv
`timescale 1ns/1ps

module irda_uart_top import irda_pkg::*; #(
	parameter logic [31:0] div_reset = 32'd1
) (
	input  logic        clk,
	input  logic        resetn,

	// register bus.
	input  logic [3:0]  reg_addr,
	input  logic [3:0]  reg_we,
	input  logic        reg_re,
	input  reg_word_t   reg_wdata,
	output logic [31:0] reg_rdata,
	output logic        reg_wait,

	// infrared transceiver side.
	output logic        ser_tx,
	input  logic        ser_rx
);

	logic [31:0]                divider;
	logic                       div_written;
	logic                       tx_start;
	logic [frame_data_bits-1:0] tx_byte;
	logic                       tx_busy;
	logic                       rx_read;
	logic                       rx_valid;
	logic [frame_data_bits-1:0] rx_byte;

	// ----------------------------------------
	// register front end
	// ----------------------------------------

	irda_reg_if #(
		.div_reset (div_reset)
	) irda_reg_if_inst (
		.clk         (clk),
		.resetn      (resetn),
		.reg_addr    (reg_addr),
		.reg_we      (reg_we),
		.reg_re      (reg_re),
		.reg_wdata   (reg_wdata),
		.reg_rdata   (reg_rdata),
		.reg_wait    (reg_wait),
		.divider     (divider),
		.div_written (div_written),
		.tx_busy     (tx_busy),
		.tx_start    (tx_start),
		.tx_byte     (tx_byte),
		.rx_valid    (rx_valid),
		.rx_byte     (rx_byte),
		.rx_read     (rx_read)
	);

	// ----------------------------------------
	// serial engines
	// ----------------------------------------

	// both engines run from the same divider, so their bit periods match.
	irda_tx irda_tx_inst (
		.clk         (clk),
		.resetn      (resetn),
		.divider     (divider),
		.div_written (div_written),
		.tx_start    (tx_start),
		.tx_byte     (tx_byte),
		.ser_tx      (ser_tx),
		.tx_busy     (tx_busy)
	);

	irda_rx irda_rx_inst (
		.clk      (clk),
		.resetn   (resetn),
		.divider  (divider),
		.ser_rx   (ser_rx),
		.rx_read  (rx_read),
		.rx_valid (rx_valid),
		.rx_byte  (rx_byte)
	);

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
	--top-module tb_irda_uart \
	--Mdir obj_dir -o sim_irda \
	-f flist.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/sim_irda
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

echo "simulation finished"
exit 0

// File: tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
	parameter int period       = 40,
	parameter int reset_cycles = 10
) (
	output logic clk,
	output logic resetn
);

	// free running clock, half a period high and half low.
	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = !clk;
	end

	// reset is held low for a fixed number of rising edges.
	initial begin
		resetn = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		resetn <= 1'b1;
	end

endmodule

// File: tb_irda_uart.sv
`timescale 1ns/1ps

module tb_irda_uart import irda_pkg::*; ();

	logic        clk;
	logic        resetn;
	logic [3:0]  reg_addr;
	logic [3:0]  reg_we;
	logic        reg_re;
	reg_word_t   reg_wdata;
	logic [31:0] reg_rdata;
	logic        reg_wait;
	logic        ser_tx;
	logic        ser_rx;

	// commands read from the golden file and the bytes sent but not yet seen on ser_tx.
	string       cmds[$];
	logic [31:0] vals[$];
	logic [7:0]  tx_expect[$];
	int          cur_div = 1;
	logic [31:0] div_model = 32'd1;
	int          cycles = 0;
	int          limit = 2000;
	logic        after_div = 1'b0;
	logic        after_send = 1'b0;

	tb_clkgen #(.period(40), .reset_cycles(10)) tb_clkgen_inst (.clk(clk), .resetn(resetn));

	irda_uart_top irda_uart_top_inst (
		.clk       (clk),
		.resetn    (resetn),
		.reg_addr  (reg_addr),
		.reg_we    (reg_we),
		.reg_re    (reg_re),
		.reg_wdata (reg_wdata),
		.reg_rdata (reg_rdata),
		.reg_wait  (reg_wait),
		.ser_tx    (ser_tx),
		.ser_rx    (ser_rx)
	);

	// the transceiver model inverts, so a positive tx pulse is a negative rx pulse.
	assign ser_rx = !ser_tx;

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("** Error: %s expected 0x%h actual 0x%h", name, expected, actual);
			$display("Test failures found");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	task automatic stop_with(input string msg);
		$display("Test failures found");
		$fatal(1, "%s", msg);
	endtask

	// ----------------------------------------
	// bus access
	// ----------------------------------------

	task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
		@(posedge clk);
		reg_addr <= addr;
		reg_re   <= 1'b1;
		@(negedge clk);
		data = reg_rdata;
		@(posedge clk);
		reg_re <= 1'b0;
	endtask

	task automatic write_reg(input logic [3:0] addr, input logic [3:0] be, input logic [31:0] data);
		@(posedge clk);
		reg_addr            <= addr;
		reg_we              <= be;
		reg_wdata.div_value <= data;
		@(posedge clk);
		reg_we <= 4'h0;
	endtask

	// the divider is written one byte lane at a time.
	// after each lane only that lane may have changed.
	task automatic write_divider(input logic [31:0] value);
		logic [31:0] mask;
		logic [31:0] rd;
		for (int i = 0; i < 4; i++) begin
			mask = 32'hff << (8 * i);
			write_reg(reg_addr_div, 4'(1 << i), value);
			div_model = (div_model & ~mask) | (value & mask);
			read_reg(reg_addr_div, rd);
			check_value("reg_rdata(div)", div_model, rd);
		end
		cur_div   = int'(value);
		after_div = 1'b1;
	endtask

	// the write is held while reg_wait is high and taken at the next edge once it is low.
	task automatic send_byte(input logic [7:0] b);
		int waits;
		waits = 0;
		@(posedge clk);
		reg_addr            <= reg_addr_dat;
		reg_we              <= 4'hf;
		reg_wdata.div_value <= {24'h0, b};
		@(negedge clk);
		while (reg_wait) begin
			waits++;
			// nothing may be sent during the guard frame.
			if (after_div) check_value("ser_tx", 32'h0, {31'h0, ser_tx});
			@(negedge clk);
		end
		tx_expect.push_back(b);
		@(posedge clk);
		reg_we <= 4'h0;
		// the wait must cover a whole guard frame after a divider change.
		if (after_div && waits < guard_bits * (cur_div + 2)) begin
			stop_with("reg_wait fell before the guard frame was over");
		end
		// a second byte has to wait for the frame in flight.
		if (after_send && waits < (frame_bits - 1) * (cur_div + 2)) begin
			stop_with("reg_wait fell before the previous frame was over");
		end
		after_div  = 1'b0;
		after_send = 1'b1;
	endtask

	// polls without a read strobe so the buffer stays intact until the byte is there.
	task automatic receive_byte(input logic [7:0] b);
		logic [31:0] rd;
		@(posedge clk);
		reg_addr <= reg_addr_dat;
		reg_re   <= 1'b0;
		@(negedge clk);
		while (reg_rdata == 32'hffff_ffff) @(negedge clk);
		read_reg(reg_addr_dat, rd);
		check_value("reg_rdata(dat)", {24'h0, b}, rd);
		read_reg(reg_addr_dat, rd);
		check_value("reg_rdata(dat)", 32'hffff_ffff, rd);
		after_send = 1'b0;
	endtask

	// ----------------------------------------
	// ser_tx frame monitor
	// ----------------------------------------

	// the first high cycle on ser_tx is the start pulse and opens the first bit window.
	// each window counts its high cycles and any pulse in it decodes as a zero bit.
	initial begin
		int         total;
		int         hi;
		int         nbit;
		int         mon_div;
		logic [9:0] frame;
		forever begin
			@(negedge clk);
			if (resetn && ser_tx) begin
				mon_div = cur_div;
				total   = frame_bits * (mon_div + 2);
				hi      = 0;
				nbit    = 0;
				for (int k = 0; k < total; k++) begin
					if (k > 0) @(negedge clk);
					if (ser_tx) hi++;
					if ((k + 1) % (mon_div + 2) == 0) begin
						if (hi != 0) check_value("ser_tx pulse width", mon_div / 4, hi);
						frame[nbit] = (hi == 0);
						nbit++;
						hi = 0;
					end
				end
				if (tx_expect.size() == 0) stop_with("frame seen on ser_tx with no byte sent");
				check_value("ser_tx stop bit", 32'h1, {31'h0, frame[9]});
				check_value("ser_tx data", {24'h0, tx_expect.pop_front()}, {24'h0, frame[8:1]});
			end
		end
	end

	// the limit grows with every send while the golden file is loaded.
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > limit) begin
			$display("Test failures found");
			$fatal(1, "timeout: the run went past %0d cycles", limit);
		end
	end

	// ----------------------------------------
	// main sequence
	// ----------------------------------------

	initial begin
		int          fd;
		int          n;
		int          d;
		string       line;
		string       cmd;
		logic [31:0] val;
		logic [31:0] rd;
		reg_addr            <= 4'h0;
		reg_we              <= 4'h0;
		reg_re              <= 1'b0;
		reg_wdata.div_value <= 32'h0;

		fd = $fopen("irda_golden.txt", "r");
		if (fd == 0) stop_with("cannot open irda_golden.txt");
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 0 && line.len() > 1 && line[0] != "#") begin
				if ($sscanf(line, "%s %h", cmd, val) == 2) begin
					cmds.push_back(cmd);
					vals.push_back(val);
				end
			end
		end
		$fclose(fd);
		// each send may sit behind a guard frame, a frame and the receive latency.
		d = 1;
		foreach (cmds[i]) begin
			if (cmds[i] == "div") d = int'(vals[i]);
			if (cmds[i] == "send") limit += 2 * 25 * (d + 2);
		end

		wait (resetn);
		// reset values of both registers and of the receive buffer.
		read_reg(reg_addr_div, rd);
		check_value("reg_rdata(div)", 32'h1, rd);
		check_value("rx_valid", 32'h0, {31'h0, irda_uart_top_inst.rx_valid});
		read_reg(reg_addr_dat, rd);
		check_value("reg_rdata(dat)", 32'hffff_ffff, rd);

		foreach (cmds[i]) begin
			if (cmds[i] == "div") begin
				write_divider(vals[i]);
			end else if (cmds[i] == "send") begin
				send_byte(vals[i][7:0]);
			end else if (cmds[i] == "expect_rx") begin
				receive_byte(vals[i][7:0]);
			end else if (cmds[i] == "expect_div") begin
				read_reg(reg_addr_div, rd);
				check_value("reg_rdata(div)", vals[i], rd);
			end else begin
				stop_with({"unknown command in golden file: ", cmds[i]});
			end
		end
		if (tx_expect.size() != 0) begin
			stop_with("a sent byte never appeared on ser_tx");
		end else begin
			$display("All tests passed!");
			$finish;
		end
	end

endmodule
